//--- src/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Core configuration
    localparam int NUM_WARPS      = 4;
    localparam int NUM_THREADS    = 4;
    localparam int NUM_CORES      = 1;
    localparam int NUM_FPU_BLOCKS = 2;

    localparam int XLEN           = 32;
    localparam int CSR_ADDR_BITS  = 12;
    localparam int NW_BITS        = $clog2(NUM_WARPS);
    localparam int FFLAGS_BITS    = 5;
    localparam int FRM_BITS       = 3;
    localparam int FCSR_BITS      = FRM_BITS + FFLAGS_BITS;
    localparam int PERF_CTR_BITS  = 64;
    localparam int COMMIT_BITS    = 2;

    typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;
    typedef logic [XLEN-1:0]          csr_data_t;
    typedef logic [NW_BITS-1:0]       wid_t;
    typedef logic [NUM_THREADS-1:0]   tmask_t;
    typedef logic [NUM_WARPS-1:0]     wmask_t;
    typedef logic [FFLAGS_BITS-1:0]   fflags_t;
    typedef logic [FRM_BITS-1:0]      frm_t;
    // Rounding mode in the upper bits, flags below
    typedef logic [FCSR_BITS-1:0]     fcsr_t;
    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;
    typedef logic [COMMIT_BITS-1:0]   commit_count_t;

    // Floating point
    localparam csr_addr_t CSR_FFLAGS      = 12'h001;
    localparam csr_addr_t CSR_FRM         = 12'h002;
    localparam csr_addr_t CSR_FCSR        = 12'h003;

    // Supervisor and machine trap setup, writes ignored
    localparam csr_addr_t CSR_SATP        = 12'h180;
    localparam csr_addr_t CSR_MSTATUS     = 12'h300;
    localparam csr_addr_t CSR_MEDELEG     = 12'h302;
    localparam csr_addr_t CSR_MIDELEG     = 12'h303;
    localparam csr_addr_t CSR_MIE         = 12'h304;
    localparam csr_addr_t CSR_MTVEC       = 12'h305;
    localparam csr_addr_t CSR_MEPC        = 12'h341;
    localparam csr_addr_t CSR_PMPCFG0     = 12'h3A0;
    localparam csr_addr_t CSR_PMPADDR0    = 12'h3B0;
    localparam csr_addr_t CSR_MNSTATUS    = 12'h744;

    // Machine information
    localparam csr_addr_t CSR_MISA        = 12'h301;
    localparam csr_addr_t CSR_MVENDORID   = 12'hF11;
    localparam csr_addr_t CSR_MARCHID     = 12'hF12;
    localparam csr_addr_t CSR_MIMPID      = 12'hF13;

    // Counters
    localparam csr_addr_t CSR_MCYCLE      = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET    = 12'hB02;
    localparam csr_addr_t CSR_MCYCLE_H    = 12'hB80;
    localparam csr_addr_t CSR_MINSTRET_H  = 12'hB82;
    localparam csr_addr_t CSR_MPM_USER    = 12'hB03;
    localparam csr_addr_t CSR_MPM_USER_H  = 12'hB83;
    localparam int        MPM_USER_COUNT  = 29;

    // Core information
    localparam csr_addr_t CSR_WARP_ID     = 12'hCC0;
    localparam csr_addr_t CSR_CORE_ID     = 12'hCC1;
    localparam csr_addr_t CSR_WARP_MASK   = 12'hCC2;
    localparam csr_addr_t CSR_THREAD_MASK = 12'hCC3;
    localparam csr_addr_t CSR_NUM_THREADS = 12'hFC0;
    localparam csr_addr_t CSR_NUM_WARPS   = 12'hFC1;
    localparam csr_addr_t CSR_NUM_CORES   = 12'hFC2;

    // Identification values
    localparam csr_data_t VENDOR_ID         = 32'h0000_0000;
    localparam csr_data_t ARCHITECTURE_ID   = 32'h0000_0007;
    localparam csr_data_t IMPLEMENTATION_ID = 32'h0000_0103;

    // MXL=1 for a 32-bit machine, extensions I, M and F
    localparam csr_data_t MISA_VALUE = (csr_data_t'(1) << (XLEN - 2))
                                     | (csr_data_t'(1) << 8)
                                     | (csr_data_t'(1) << 12)
                                     | (csr_data_t'(1) << 5);

endpackage

`default_nettype wire

//--- src/fcsr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module fcsr_regs import csr_pkg::*; (
    input  wire                               clk,
    input  wire                               reset,

    input  wire                               write_enable,
    input  csr_addr_t                         write_addr,
    input  wid_t                              write_wid,
    input  csr_data_t                         write_data,

    input  wire [NUM_FPU_BLOCKS-1:0]          fpu_flags_valid,
    input  wid_t    [NUM_FPU_BLOCKS-1:0]      fpu_flags_wid,
    input  fflags_t [NUM_FPU_BLOCKS-1:0]      fpu_flags,

    input  wid_t    [NUM_FPU_BLOCKS-1:0]      fpu_frm_wid,
    output frm_t    [NUM_FPU_BLOCKS-1:0]      fpu_frm,

    output fcsr_t   [NUM_WARPS-1:0]           fcsr_state,
    output logic                              write_addr_valid
);

    fcsr_t [NUM_WARPS-1:0] fcsr_r;
    fcsr_t [NUM_WARPS-1:0] fcsr_n;

    // Address decode, independent of write_enable
    always_comb begin
        case (write_addr)
            CSR_FFLAGS,
            CSR_FRM,
            CSR_FCSR,
            CSR_SATP,
            CSR_MSTATUS,
            CSR_MNSTATUS,
            CSR_MEDELEG,
            CSR_MIDELEG,
            CSR_MIE,
            CSR_MTVEC,
            CSR_MEPC,
            CSR_PMPCFG0,
            CSR_PMPADDR0: write_addr_valid = 1'b1;
            default:      write_addr_valid = 1'b0;
        endcase
    end

    always_comb begin
        fcsr_n = fcsr_r;
        // Accrue FPU flags first, several blocks may hit one warp
        for (int i = 0; i < NUM_FPU_BLOCKS; i++) begin
            if (fpu_flags_valid[i]) begin
                fcsr_n[fpu_flags_wid[i]][FFLAGS_BITS-1:0] =
                    fcsr_n[fpu_flags_wid[i]][FFLAGS_BITS-1:0] | fpu_flags[i];
            end
        end
        // CSR write then overrides the addressed field
        if (write_enable) begin
            case (write_addr)
                CSR_FFLAGS: fcsr_n[write_wid][FFLAGS_BITS-1:0] = write_data[FFLAGS_BITS-1:0];
                CSR_FRM:    fcsr_n[write_wid][FCSR_BITS-1:FFLAGS_BITS] = write_data[FRM_BITS-1:0];
                CSR_FCSR:   fcsr_n[write_wid] = write_data[FCSR_BITS-1:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fcsr_r <= '0;
        end else begin
            fcsr_r <= fcsr_n;
        end
    end

    // Rounding-mode lookups for the FPU blocks
    for (genvar i = 0; i < NUM_FPU_BLOCKS; i++) begin : g_frm
        assign fpu_frm[i] = fcsr_r[fpu_frm_wid[i]][FCSR_BITS-1:FFLAGS_BITS];
    end

    assign fcsr_state = fcsr_r;

endmodule

`default_nettype wire

//--- src/perf_counters.sv
`timescale 1ns/10ps
`default_nettype none

module perf_counters import csr_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  commit_count_t commit_count,
    output perf_ctr_t     cycles,
    output perf_ctr_t     instret
);

    perf_ctr_t cycles_r;
    perf_ctr_t instret_r;

    // Free-running cycle count
    always_ff @(posedge clk) begin
        if (reset) begin
            cycles_r <= '0;
        end else begin
            cycles_r <= cycles_r + perf_ctr_t'(1);
        end
    end

    // Retired instructions, up to three per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            instret_r <= '0;
        end else begin
            instret_r <= instret_r + perf_ctr_t'(commit_count);
        end
    end

    assign cycles  = cycles_r;
    assign instret = instret_r;

endmodule

`default_nettype wire

//--- src/csr_read_mux.sv
`timescale 1ns/10ps
`default_nettype none

module csr_read_mux import csr_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  csr_addr_t                 read_addr,
    input  wid_t                      read_wid,

    input  fcsr_t  [NUM_WARPS-1:0]    fcsr_state,

    input  perf_ctr_t                 cycles,
    input  perf_ctr_t                 instret,

    input  wmask_t                    active_warps,
    input  tmask_t [NUM_WARPS-1:0]    thread_masks,

    output csr_data_t                 read_data_ro,
    output csr_data_t                 read_data_rw,
    output logic                      read_addr_valid
);

    fcsr_t   sel_fcsr;
    fflags_t sel_fflags;
    frm_t    sel_frm;
    logic    in_mpm_user;
    logic    in_mpm_user_h;

    assign sel_fcsr   = fcsr_state[read_wid];
    assign sel_fflags = sel_fcsr[FFLAGS_BITS-1:0];
    assign sel_frm    = sel_fcsr[FCSR_BITS-1:FFLAGS_BITS];

    // User counter windows, both read as zero
    assign in_mpm_user   = (read_addr >= CSR_MPM_USER)
                        && (int'(read_addr) < int'(CSR_MPM_USER) + MPM_USER_COUNT);
    assign in_mpm_user_h = (read_addr >= CSR_MPM_USER_H)
                        && (int'(read_addr) < int'(CSR_MPM_USER_H) + MPM_USER_COUNT);

    always_comb begin
        read_data_ro    = '0;
        read_data_rw    = '0;
        read_addr_valid = 1'b1;
        case (read_addr)
            // Read-write floating point view
            CSR_FFLAGS:      read_data_rw = csr_data_t'(sel_fflags);
            CSR_FRM:         read_data_rw = csr_data_t'(sel_frm);
            CSR_FCSR:        read_data_rw = csr_data_t'(sel_fcsr);

            CSR_MVENDORID:   read_data_ro = VENDOR_ID;
            CSR_MARCHID:     read_data_ro = ARCHITECTURE_ID;
            CSR_MIMPID:      read_data_ro = IMPLEMENTATION_ID;
            CSR_MISA:        read_data_ro = MISA_VALUE;

            CSR_WARP_ID:     read_data_ro = csr_data_t'(read_wid);
            CSR_CORE_ID:     read_data_ro = csr_data_t'(CORE_ID);
            CSR_WARP_MASK:   read_data_ro = csr_data_t'(active_warps);
            CSR_THREAD_MASK: read_data_ro = csr_data_t'(thread_masks[read_wid]);
            CSR_NUM_THREADS: read_data_ro = csr_data_t'(NUM_THREADS);
            CSR_NUM_WARPS:   read_data_ro = csr_data_t'(NUM_WARPS);
            CSR_NUM_CORES:   read_data_ro = csr_data_t'(NUM_CORES);

            // Counter halves
            CSR_MCYCLE:      read_data_ro = cycles[XLEN-1:0];
            CSR_MCYCLE_H:    read_data_ro = cycles[PERF_CTR_BITS-1:XLEN];
            CSR_MINSTRET:    read_data_ro = instret[XLEN-1:0];
            CSR_MINSTRET_H:  read_data_ro = instret[PERF_CTR_BITS-1:XLEN];

            // Trap registers are not implemented
            CSR_SATP,
            CSR_MSTATUS,
            CSR_MNSTATUS,
            CSR_MEDELEG,
            CSR_MIDELEG,
            CSR_MIE,
            CSR_MTVEC,
            CSR_MEPC,
            CSR_PMPCFG0,
            CSR_PMPADDR0:    read_data_ro = '0;

            default: begin
                read_addr_valid = in_mpm_user || in_mpm_user_h;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/csr_data.sv
`timescale 1ns/10ps
`default_nettype none

module csr_data import csr_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  wire                               clk,
    input  wire                               reset,

    input  csr_addr_t                         read_addr,
    input  wid_t                              read_wid,
    output csr_data_t                         read_data_ro,
    output csr_data_t                         read_data_rw,
    output logic                              read_addr_valid,

    input  wire                               write_enable,
    input  csr_addr_t                         write_addr,
    input  wid_t                              write_wid,
    input  csr_data_t                         write_data,
    output logic                              write_addr_valid,

    input  wire [NUM_FPU_BLOCKS-1:0]          fpu_flags_valid,
    input  wid_t    [NUM_FPU_BLOCKS-1:0]      fpu_flags_wid,
    input  fflags_t [NUM_FPU_BLOCKS-1:0]      fpu_flags,
    input  wid_t    [NUM_FPU_BLOCKS-1:0]      fpu_frm_wid,
    output frm_t    [NUM_FPU_BLOCKS-1:0]      fpu_frm,

    input  commit_count_t                     commit_count,
    input  wmask_t                            active_warps,
    input  tmask_t  [NUM_WARPS-1:0]           thread_masks
);

    fcsr_t [NUM_WARPS-1:0] fcsr_state;
    perf_ctr_t             cycles;
    perf_ctr_t             instret;

    fcsr_regs i_fcsr_regs (
        .clk              (clk),
        .reset            (reset),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_wid        (write_wid),
        .write_data       (write_data),
        .fpu_flags_valid  (fpu_flags_valid),
        .fpu_flags_wid    (fpu_flags_wid),
        .fpu_flags        (fpu_flags),
        .fpu_frm_wid      (fpu_frm_wid),
        .fpu_frm          (fpu_frm),
        .fcsr_state       (fcsr_state),
        .write_addr_valid (write_addr_valid)
    );

    perf_counters i_perf_counters (
        .clk          (clk),
        .reset        (reset),
        .commit_count (commit_count),
        .cycles       (cycles),
        .instret      (instret)
    );

    csr_read_mux #(
        .CORE_ID (CORE_ID)
    ) i_csr_read_mux (
        .read_addr       (read_addr),
        .read_wid        (read_wid),
        .fcsr_state      (fcsr_state),
        .cycles          (cycles),
        .instret         (instret),
        .active_warps    (active_warps),
        .thread_masks    (thread_masks),
        .read_data_ro    (read_data_ro),
        .read_data_rw    (read_data_rw),
        .read_addr_valid (read_addr_valid)
    );

endmodule

`default_nettype wire

//--- sim/csr_data_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module csr_data_assertions import csr_pkg::*; (
    input wire       clk,
    input wire       reset,
    input csr_data_t read_data_ro,
    input csr_data_t read_data_rw,
    input wire       read_addr_valid,
    input perf_ctr_t cycles
);

    // Unmapped reads return zero on both outputs
    invalid_read_zero: assert property (
        @(posedge clk) disable iff (reset)
        !read_addr_valid |-> (read_data_ro == '0 && read_data_rw == '0)
    ) else $error("invalid read address returned nonzero data");

    one_data_output: assert property (
        @(posedge clk) disable iff (reset)
        !(read_data_ro != '0 && read_data_rw != '0)
    ) else $error("read_data_ro and read_data_rw both nonzero");

    // Cycle count only moves forward out of reset
    mcycle_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> cycles >= $past(cycles)
    ) else $error("mcycle decreased");

endmodule

bind csr_data csr_data_assertions i_csr_data_assertions (
    .clk             (clk),
    .reset           (reset),
    .read_data_ro    (read_data_ro),
    .read_data_rw    (read_data_rw),
    .read_addr_valid (read_addr_valid),
    .cycles          (cycles)
);

`default_nettype wire

//--- sim/csr_data_tb.sv
`timescale 1ns/10ps
`default_nettype none

module csr_data_tb import csr_pkg::*; ();

    logic                         clk;
    logic                         reset;
    csr_addr_t                    read_addr;
    wid_t                         read_wid;
    csr_data_t                    read_data_ro;
    csr_data_t                    read_data_rw;
    logic                         read_addr_valid;
    logic                         write_enable;
    csr_addr_t                    write_addr;
    wid_t                         write_wid;
    csr_data_t                    write_data;
    logic                         write_addr_valid;
    logic [NUM_FPU_BLOCKS-1:0]    fpu_flags_valid;
    wid_t [NUM_FPU_BLOCKS-1:0]    fpu_flags_wid;
    fflags_t [NUM_FPU_BLOCKS-1:0] fpu_flags;
    wid_t [NUM_FPU_BLOCKS-1:0]    fpu_frm_wid;
    frm_t [NUM_FPU_BLOCKS-1:0]    fpu_frm;
    commit_count_t                commit_count;
    wmask_t                       active_warps;
    tmask_t [NUM_WARPS-1:0]       thread_masks;

    integer    seed;
    int        check_count;
    int        error_count;
    int        test_count;
    int        start_checks;
    int        start_errors;
    fcsr_t     saved_fcsr [NUM_WARPS];

    // Reference model
    fcsr_t     m_fcsr [NUM_WARPS];
    perf_ctr_t m_cycles;
    perf_ctr_t m_instret;

    // FP 0..2, ignored 3..12, machine info 13..16, counters 17..20, core info 21..27
    csr_addr_t known_addrs [28] = '{
        CSR_FFLAGS, CSR_FRM, CSR_FCSR,
        CSR_SATP, CSR_MSTATUS, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE,
        CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0, CSR_MNSTATUS,
        CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
        CSR_MCYCLE, CSR_MINSTRET, CSR_MCYCLE_H, CSR_MINSTRET_H,
        CSR_WARP_ID, CSR_CORE_ID, CSR_WARP_MASK, CSR_THREAD_MASK,
        CSR_NUM_THREADS, CSR_NUM_WARPS, CSR_NUM_CORES
    };

    csr_data #(.CORE_ID(3)) i_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic check_data(input string name, input csr_data_t exp, input csr_data_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_frm(input string name, input frm_t exp, input frm_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic begin_test();
        start_checks = check_count;
        start_errors = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d checks, %0d errors", test_count, name,
                 check_count - start_checks, error_count - start_errors);
    endtask

    // Model update with the inputs held across the edge
    function automatic void apply_edge();
        if (reset) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                m_fcsr[w] = '0;
            end
            m_cycles  = '0;
            m_instret = '0;
        end else begin
            for (int b = 0; b < NUM_FPU_BLOCKS; b++) begin
                if (fpu_flags_valid[b]) begin
                    m_fcsr[fpu_flags_wid[b]][4:0] = m_fcsr[fpu_flags_wid[b]][4:0] | fpu_flags[b];
                end
            end
            if (write_enable && write_addr == CSR_FFLAGS) begin
                m_fcsr[write_wid][4:0] = write_data[4:0];
            end else if (write_enable && write_addr == CSR_FRM) begin
                m_fcsr[write_wid][7:5] = write_data[2:0];
            end else if (write_enable && write_addr == CSR_FCSR) begin
                m_fcsr[write_wid] = write_data[7:0];
            end
            m_cycles  = m_cycles + perf_ctr_t'(1);
            m_instret = m_instret + perf_ctr_t'(commit_count);
        end
    endfunction

    function automatic void expect_read(input csr_addr_t addr, input wid_t wid,
                                        output csr_data_t ro, output csr_data_t rw,
                                        output logic valid);
        ro    = '0;
        rw    = '0;
        valid = 1'b1;
        case (addr)
            CSR_FFLAGS:      rw = csr_data_t'(m_fcsr[wid][4:0]);
            CSR_FRM:         rw = csr_data_t'(m_fcsr[wid][7:5]);
            CSR_FCSR:        rw = csr_data_t'(m_fcsr[wid]);
            CSR_MVENDORID:   ro = VENDOR_ID;
            CSR_MARCHID:     ro = ARCHITECTURE_ID;
            CSR_MIMPID:      ro = IMPLEMENTATION_ID;
            // MXL 1 in bits 31:30, extensions F, I and M
            CSR_MISA:        ro = 32'h4000_0000 | (32'h1 << 5) | (32'h1 << 8) | (32'h1 << 12);
            CSR_WARP_ID:     ro = csr_data_t'(wid);
            CSR_CORE_ID:     ro = csr_data_t'(3);
            CSR_WARP_MASK:   ro = csr_data_t'(active_warps);
            CSR_THREAD_MASK: ro = csr_data_t'(thread_masks[wid]);
            CSR_NUM_THREADS: ro = csr_data_t'(NUM_THREADS);
            CSR_NUM_WARPS:   ro = csr_data_t'(NUM_WARPS);
            CSR_NUM_CORES:   ro = csr_data_t'(NUM_CORES);
            CSR_MCYCLE:      ro = m_cycles[31:0];
            CSR_MCYCLE_H:    ro = m_cycles[63:32];
            CSR_MINSTRET:    ro = m_instret[31:0];
            CSR_MINSTRET_H:  ro = m_instret[63:32];
            CSR_SATP, CSR_MSTATUS, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE,
            CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0, CSR_MNSTATUS: begin
            end
            default: begin
                valid = (addr >= CSR_MPM_USER && addr < CSR_MPM_USER + 12'd29)
                     || (addr >= CSR_MPM_USER_H && addr < CSR_MPM_USER_H + 12'd29);
            end
        endcase
    endfunction

    function automatic logic expect_write_valid(input csr_addr_t addr);
        case (addr)
            CSR_FFLAGS, CSR_FRM, CSR_FCSR,
            CSR_SATP, CSR_MSTATUS, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE,
            CSR_MTVEC, CSR_MEPC, CSR_PMPCFG0, CSR_PMPADDR0, CSR_MNSTATUS: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic csr_addr_t fp_addr(input logic [31:0] r);
        case (r % 32'd3)
            32'd0:   return CSR_FFLAGS;
            32'd1:   return CSR_FRM;
            default: return CSR_FCSR;
        endcase
    endfunction

    // Mix of any address, the counter page and the mapped registers
    function automatic csr_addr_t random_addr(input logic [31:0] r);
        int idx;
        idx = int'(r[20:16] % 5'd28);
        case (r[31:30])
            2'd0:    return r[11:0];
            2'd1:    return {4'hB, r[7:0]};
            default: return known_addrs[idx];
        endcase
    endfunction

    task automatic tick();
        @(posedge clk);
        apply_edge();
        #1;
    endtask

    task automatic idle_inputs();
        write_enable    = 1'b0;
        fpu_flags_valid = '0;
        commit_count    = '0;
    endtask

    task automatic read_and_check(input csr_addr_t addr, input wid_t wid);
        csr_data_t exp_ro;
        csr_data_t exp_rw;
        logic      exp_valid;
        read_addr = addr;
        read_wid  = wid;
        #10;
        expect_read(addr, wid, exp_ro, exp_rw, exp_valid);
        check_data($sformatf("read_data_ro @%h", addr), exp_ro, read_data_ro);
        check_data($sformatf("read_data_rw @%h", addr), exp_rw, read_data_rw);
        check_bit($sformatf("read_addr_valid @%h", addr), exp_valid, read_addr_valid);
    endtask

    task automatic sweep_fp();
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int a = 0; a < 3; a++) begin
                tick();
                read_and_check(known_addrs[a], wid_t'(w));
            end
        end
    endtask

    task automatic wait_counter_start();
        int n;
        n = 0;
        tick();
        read_addr = CSR_MCYCLE;
        #10;
        while (read_data_ro == '0 && n < 10) begin
            tick();
            #10;
            n++;
        end
        if (read_data_ro == '0) begin
            $display("timeout: cycle counter did not start after reset");
            $display("tests failed");
            $finish;
        end
    endtask

    initial begin
        logic [31:0] r;
        csr_addr_t   addr;
        seed = 32'h542b95ea;
        clk = 1'b0;
        reset = 1'b1;
        read_addr = '0;
        read_wid = '0;
        write_enable = 1'b0;
        write_addr = '0;
        write_wid = '0;
        write_data = '0;
        fpu_flags_valid = '0;
        fpu_flags_wid = '0;
        fpu_flags = '0;
        fpu_frm_wid = '0;
        commit_count = '0;
        active_warps = '0;
        thread_masks = '0;
        check_count = 0;
        error_count = 0;
        test_count = 0;
        repeat (3) tick();
        reset = 1'b0;
        wait_counter_start();

        begin_test();
        sweep_fp();
        for (int i = 13; i < 28; i++) begin
            tick();
            read_and_check(known_addrs[i], '0);
        end
        end_test("reset values");

        begin_test();
        for (int i = 0; i < 40; i++) begin
            tick();
            r = rand32();
            write_enable = 1'b1;
            write_addr = fp_addr(rand32());
            write_wid = r[1:0];
            write_data = rand32();
            read_and_check(fp_addr(rand32()), r[3:2]);
            check_bit("write_addr_valid", expect_write_valid(write_addr), write_addr_valid);
        end
        tick();
        idle_inputs();
        sweep_fp();
        end_test("fcsr write readback");

        // Flag reports racing CSR writes, several blocks on one warp
        begin_test();
        for (int i = 0; i < 60; i++) begin
            tick();
            r = rand32();
            fpu_flags_valid = r[1:0];
            fpu_flags_wid = r[5:2];
            fpu_flags = r[15:6];
            fpu_frm_wid = r[19:16];
            write_enable = r[20];
            write_wid = r[22:21];
            write_addr = fp_addr(rand32());
            write_data = rand32();
            read_and_check(fp_addr(rand32()), r[24:23]);
            for (int b = 0; b < NUM_FPU_BLOCKS; b++) begin
                check_frm($sformatf("fpu_frm[%0d]", b), m_fcsr[fpu_frm_wid[b]][7:5], fpu_frm[b]);
            end
        end
        tick();
        idle_inputs();
        sweep_fp();
        end_test("flag accrual");

        begin_test();
        for (int i = 0; i < 40; i++) begin
            tick();
            r = rand32();
            commit_count = r[1:0];
            read_and_check(known_addrs[17 + int'(r[3:2])], r[5:4]);
        end
        end_test("counters");

        begin_test();
        for (int i = 0; i < 30; i++) begin
            tick();
            r = rand32();
            active_warps = r[3:0];
            thread_masks = r[19:4];
            read_and_check(known_addrs[21 + int'(r[21:20])], r[23:22]);
        end
        end_test("warp and thread masks");

        begin_test();
        for (int w = 0; w < NUM_WARPS; w++) begin
            saved_fcsr[w] = m_fcsr[w];
        end
        for (int i = 0; i < 80; i++) begin
            tick();
            r = rand32();
            addr = random_addr(rand32());
            if (addr == CSR_FFLAGS || addr == CSR_FRM || addr == CSR_FCSR) begin
                addr = CSR_MEPC;
            end
            write_enable = 1'b1;
            write_addr = addr;
            write_wid = r[1:0];
            write_data = rand32();
            read_and_check(random_addr(rand32()), r[3:2]);
            check_bit($sformatf("write_addr_valid @%h", addr), expect_write_valid(addr),
                      write_addr_valid);
        end
        tick();
        idle_inputs();
        for (int w = 0; w < NUM_WARPS; w++) begin
            tick();
            read_and_check(CSR_FCSR, wid_t'(w));
            check_data("read_data_rw fcsr after ignored writes", csr_data_t'(saved_fcsr[w]),
                       read_data_rw);
        end
        end_test("address validity");

        $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
src/csr_pkg.sv
src/fcsr_regs.sv
src/perf_counters.sv
src/csr_read_mux.sv
src/csr_data.sv
sim/csr_data_assertions.sv
sim/csr_data_tb.sv

//--- Makefile
TOP = csr_data_tb

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
